// ==== common/rtab_cfg_pkg.sv ====
// Sizing constants for the replay table and its address fields, imported by RTL and testbench
package rtab_cfg_pkg;

    // Table geometry
    localparam int RTAB_ENTRIES = 4;
    localparam int RTAB_PTR_W = 2;

    // Request address split into tag, set and line offset
    localparam int ADDR_W = 16;
    localparam int CL_OFF_W = 4;
    localparam int SET_W = 4;
    localparam int TAG_W = 8;

    // A line number is the tag and the set together
    localparam int NLINE_W = TAG_W + SET_W;

    // Requester tag, carried through the table untouched
    localparam int REQ_ID_W = 4;

endpackage

// ==== common/rtab_types_pkg.sv ====
// Data types shared by the replay table modules and its testbench
package rtab_types_pkg;
    import rtab_cfg_pkg::*;

    typedef logic [RTAB_PTR_W-1:0] rtab_ptr_t;
    typedef logic [RTAB_ENTRIES-1:0] rtab_bv_t;
    typedef logic [NLINE_W-1:0] rtab_nline_t;

    // Address seen as tag, set and offset (set comparison)
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [SET_W-1:0] set;
        logic [CL_OFF_W-1:0] offset;
    } rtab_addr_tso_t;

    // Address seen as line number and offset (line comparisons)
    typedef struct packed {
        rtab_nline_t nline;
        logic [CL_OFF_W-1:0] offset;
    } rtab_addr_lo_t;

    typedef union packed {
        rtab_addr_tso_t tso;
        rtab_addr_lo_t lo;
        logic [ADDR_W-1:0] raw;
    } rtab_addr_u;

    typedef struct packed {
        rtab_addr_u addr;
        logic [REQ_ID_W-1:0] id;
    } rtab_req_t;

    // Miss handler dependencies, an entry replays only when all are clear
    typedef struct packed {
        logic mshr_hit;
        logic mshr_full;
        logic mshr_ready;
    } rtab_deps_t;

    typedef struct packed {
        logic valid;
        logic link;
        rtab_req_t req;
        rtab_deps_t deps;
    } rtab_alloc_t;

    typedef struct packed {
        logic valid;
        rtab_ptr_t ptr;
        rtab_deps_t deps;
    } rtab_rback_t;

    typedef struct packed {
        logic valid;
        rtab_ptr_t ptr;
    } rtab_commit_t;

    typedef struct packed {
        logic valid;
        rtab_nline_t nline;
    } rtab_refill_t;

endpackage

// ==== dv/rtab_tb.sv ====
// Self-checking testbench that applies a stimulus table to the replay table against a list model
`timescale 1ns/1ps

module rtab_tb import rtab_cfg_pkg::*, rtab_types_pkg::*;;

    typedef enum logic [2:0] {
        OP_IDLE, OP_ALLOC, OP_LINK, OP_COMMIT, OP_RBACK, OP_REFILL, OP_MREADY
    } op_e;

    // Stimulus row followed by expected check hit, empty and full
    typedef struct packed {
        op_e op;
        rtab_nline_t nline;
        rtab_deps_t deps;
        rtab_ptr_t ptr;
        logic pop;
        logic hit;
        logic empty;
        logic full;
    } row_t;

    localparam int NROWS = 38;
    localparam int TIMEOUT_CYCLES = 10 * NROWS + 50;
    localparam logic [31:0] SEED = 32'hfdad_adc6;

    // Lines A and C share set 3 and B5 is another line in the set of B
    localparam rtab_nline_t LN_0 = 12'h000;
    localparam rtab_nline_t LN_A = 12'h1a3;
    localparam rtab_nline_t LN_B = 12'h2b5;
    localparam rtab_nline_t LN_C = 12'h3c3;
    localparam rtab_nline_t LN_D = 12'h4d7;
    localparam rtab_nline_t LN_B5 = 12'h9b5;

    // Row columns are op, line, deps {hit, full, ready}, ptr, pop, exp hit, exp empty and exp full
    localparam row_t ROWS [NROWS] = '{
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{OP_ALLOC,  LN_A,  3'b100, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{OP_ALLOC,  LN_B,  3'b010, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ALLOC,  LN_D,  3'b001, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ALLOC,  LN_C,  3'b100, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,   LN_A,  3'b000, 2'd0, 1'b0, 1'b1, 1'b0, 1'b1},
        '{OP_REFILL, LN_B5, 3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b1},
        '{OP_COMMIT, LN_0,  3'b000, 2'd1, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_REFILL, LN_A,  3'b000, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OP_COMMIT, LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MREADY, LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OP_COMMIT, LN_0,  3'b000, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_REFILL, LN_C,  3'b000, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OP_COMMIT, LN_0,  3'b000, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ALLOC,  LN_D,  3'b000, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OP_COMMIT, LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ALLOC,  LN_A,  3'b000, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{OP_ALLOC,  LN_B,  3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_LINK,   LN_A,  3'b000, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{OP_LINK,   LN_A,  3'b000, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b1},
        '{OP_COMMIT, LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b1},
        '{OP_COMMIT, LN_0,  3'b000, 2'd2, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OP_COMMIT, LN_0,  3'b000, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OP_RBACK,  LN_0,  3'b010, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_REFILL, LN_B5, 3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OP_COMMIT, LN_0,  3'b000, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,   LN_0,  3'b000, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0}
    };

    logic clk_i;
    logic rst_ni;
    rtab_nline_t check_nline_i;
    logic check_hit_o;
    rtab_alloc_t alloc_i;
    rtab_commit_t commit_i;
    rtab_rback_t rback_i;
    rtab_refill_t refill_i;
    logic miss_ready_i;
    logic pop_try_i;
    logic pop_try_valid_o;
    rtab_req_t pop_try_req_o;
    rtab_ptr_t pop_try_ptr_o;
    logic empty_o;
    logic full_o;

    // Reference model of the flags, lists and round-robin position
    rtab_bv_t m_valid, m_head, m_tail;
    rtab_deps_t m_deps [RTAB_ENTRIES];
    rtab_ptr_t m_next [RTAB_ENTRIES];
    rtab_req_t m_req [RTAB_ENTRIES];
    logic walking;
    rtab_ptr_t walk_ptr;
    int rr_start;

    row_t row;
    rtab_req_t new_req;
    int head_idx;
    logic exp_valid;
    rtab_ptr_t exp_ptr;
    int errors;
    int checks;
    int cycle_cnt;

    rtab_top rtab_top_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .check_nline_i   (check_nline_i),
        .check_hit_o     (check_hit_o),
        .alloc_i         (alloc_i),
        .commit_i        (commit_i),
        .rback_i         (rback_i),
        .refill_i        (refill_i),
        .miss_ready_i    (miss_ready_i),
        .pop_try_i       (pop_try_i),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_try_req_o   (pop_try_req_o),
        .pop_try_ptr_o   (pop_try_ptr_o),
        .empty_o         (empty_o),
        .full_o          (full_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input int idx, input string what,
                               input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: row %0d %s is %0h, expected %0h",
                     $time, idx, what, got, exp);
        end
    endtask

    // First ready list head searched from the round-robin position
    function automatic int pick_head();
        int idx;
        for (int k = 0; k < RTAB_ENTRIES; k++) begin
            idx = (rr_start + k) % RTAB_ENTRIES;
            if (m_valid[idx] && m_head[idx] && m_deps[idx] == '0) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic clear_inputs();
        check_nline_i = '0;
        alloc_i = '0;
        commit_i = '0;
        rback_i = '0;
        refill_i = '0;
        miss_ready_i = 1'b0;
        pop_try_i = 1'b0;
    endtask

    task automatic drive_row(input row_t r, input rtab_req_t req);
        clear_inputs();
        check_nline_i = r.nline;
        pop_try_i = r.pop;
        case (r.op)
            OP_ALLOC, OP_LINK: begin
                alloc_i.valid = 1'b1;
                alloc_i.link = (r.op == OP_LINK);
                alloc_i.req = req;
                alloc_i.deps = r.deps;
            end
            OP_COMMIT: begin
                commit_i.valid = 1'b1;
                commit_i.ptr = r.ptr;
            end
            OP_RBACK: begin
                rback_i.valid = 1'b1;
                rback_i.ptr = r.ptr;
                rback_i.deps = r.deps;
            end
            OP_REFILL: begin
                refill_i.valid = 1'b1;
                refill_i.nline = r.nline;
            end
            OP_MREADY: miss_ready_i = 1'b1;
            default: begin
            end
        endcase
    endtask

    // Advance the model by one clock edge
    task automatic model_step(input row_t r, input rtab_req_t req, input int hidx,
                              input rtab_ptr_t ptr, input logic take);
        int slot;
        slot = 0;
        for (int k = RTAB_ENTRIES - 1; k >= 0; k--) begin
            if (!m_valid[k]) begin
                slot = k;
            end
        end
        if (take && !walking) begin
            rr_start = (int'(ptr) + 1) % RTAB_ENTRIES;
        end else if (hidx >= 0) begin
            rr_start = hidx;
        end
        if (take) begin
            m_head[ptr] = 1'b0;
            walking = !m_tail[ptr];
            walk_ptr = m_next[ptr];
        end
        for (int t = 0; t < RTAB_ENTRIES; t++) begin
            if (r.op == OP_LINK && m_valid[t] && m_tail[t]
                    && m_req[t].addr.lo.nline == r.nline) begin
                m_tail[t] = 1'b0;
                m_next[t] = rtab_ptr_t'(slot);
            end
            if (r.op == OP_REFILL && m_req[t].addr.lo.nline == r.nline) begin
                m_deps[t].mshr_hit = 1'b0;
            end
            if (r.op == OP_REFILL && m_req[t].addr.tso.set == r.nline[SET_W-1:0]) begin
                m_deps[t].mshr_full = 1'b0;
            end
            if (r.op == OP_MREADY) begin
                m_deps[t].mshr_ready = 1'b0;
            end
        end
        if (r.op == OP_ALLOC || r.op == OP_LINK) begin
            m_valid[slot] = 1'b1;
            m_head[slot] = (r.op == OP_ALLOC);
            m_tail[slot] = 1'b1;
            m_deps[slot] = r.deps;
            m_req[slot] = req;
        end else if (r.op == OP_COMMIT) begin
            m_valid[r.ptr] = 1'b0;
            m_tail[r.ptr] = 1'b0;
        end else if (r.op == OP_RBACK) begin
            m_head[r.ptr] = 1'b1;
            m_deps[r.ptr] = r.deps;
            walking = 1'b0;
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the table was not finished after %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        clear_inputs();
        rst_ni = 1'b0;
        m_valid = '0;
        m_head = '0;
        m_tail = '0;
        walking = 1'b0;
        walk_ptr = '0;
        rr_start = 0;
        for (int k = 0; k < RTAB_ENTRIES; k++) begin
            m_deps[k] = '0;
            m_next[k] = '0;
            m_req[k] = '0;
        end
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            row = ROWS[r];
            new_req.addr.lo.nline = row.nline;
            new_req.addr.lo.offset = CL_OFF_W'($urandom);
            new_req.id = REQ_ID_W'($urandom);
            drive_row(row, new_req);
            #10;
            head_idx = pick_head();
            exp_valid = walking || (head_idx >= 0);
            exp_ptr = walking ? walk_ptr : rtab_ptr_t'(head_idx);
            check_value(r, "check_hit_o", 32'(check_hit_o), 32'(row.hit));
            check_value(r, "empty_o", 32'(empty_o), 32'(row.empty));
            check_value(r, "full_o", 32'(full_o), 32'(row.full));
            check_value(r, "pop_try_valid_o", 32'(pop_try_valid_o), 32'(exp_valid));
            if (exp_valid) begin
                check_value(r, "pop_try_ptr_o", 32'(pop_try_ptr_o), 32'(exp_ptr));
                check_value(r, "pop_try_req_o", 32'(pop_try_req_o), 32'(m_req[exp_ptr]));
            end
            model_step(row, new_req, head_idx, exp_ptr, row.pop && exp_valid);
            @(negedge clk_i);
        end
        clear_inputs();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== hw/rtab/rtab_flags.sv ====
// Replay table entry flags: valid, list head and tail, dependencies, free entry and status
`timescale 1ns/1ps

module rtab_flags import rtab_cfg_pkg::*, rtab_types_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  rtab_alloc_t  alloc_i,
    input  rtab_commit_t commit_i,
    input  rtab_rback_t  rback_i,
    input  logic         refill_valid_i,
    input  logic         miss_ready_i,
    input  rtab_bv_t     check_match_i,
    input  rtab_bv_t     refill_line_match_i,
    input  rtab_bv_t     refill_set_match_i,
    input  rtab_bv_t     pop_take_i,
    output logic         check_hit_o,
    output rtab_bv_t     link_tail_o,
    output rtab_ptr_t    alloc_ptr_o,
    output rtab_bv_t     ready_o,
    output rtab_bv_t     tail_o,
    output logic         empty_o,
    output logic         full_o
);

    rtab_bv_t valid_q, valid_d;
    rtab_bv_t head_q, head_d;
    rtab_bv_t tail_q, tail_d;
    rtab_deps_t [RTAB_ENTRIES-1:0] deps_q, deps_d;
    rtab_bv_t free;
    rtab_bv_t alloc_1h;
    rtab_bv_t check_hit;
    rtab_bv_t nodeps;

    assign check_hit = check_match_i & valid_q;
    assign check_hit_o = |check_hit;
    assign link_tail_o = check_hit & tail_q;

    // Lowest free entry, as one-hot and as index
    assign free = ~valid_q;
    assign alloc_1h = free & (~free + 1'b1);

    always_comb begin
        alloc_ptr_o = '0;
        for (int i = RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (free[i]) begin
                alloc_ptr_o = rtab_ptr_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            nodeps[i] = ~|deps_q[i];
        end
    end

    assign ready_o = valid_q & head_q & nodeps;
    assign tail_o = tail_q;
    assign empty_o = ~|valid_q;
    assign full_o = &valid_q;

    always_comb begin
        valid_d = valid_q;
        // A taken entry leaves the head set until it is rolled back
        head_d = head_q & ~pop_take_i;
        tail_d = tail_q;
        deps_d = deps_q;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (refill_valid_i && refill_line_match_i[i]) begin
                deps_d[i].mshr_hit = 1'b0;
            end
            if (refill_valid_i && refill_set_match_i[i]) begin
                deps_d[i].mshr_full = 1'b0;
            end
            if (miss_ready_i) begin
                deps_d[i].mshr_ready = 1'b0;
            end
            if (commit_i.valid && commit_i.ptr == rtab_ptr_t'(i)) begin
                valid_d[i] = 1'b0;
                tail_d[i] = 1'b0;
            end
            if (rback_i.valid && rback_i.ptr == rtab_ptr_t'(i)) begin
                head_d[i] = 1'b1;
                deps_d[i] = rback_i.deps;
            end
            // Old tail hands its role to the linked entry
            if (alloc_i.valid && alloc_i.link && link_tail_o[i]) begin
                tail_d[i] = 1'b0;
            end
            if (alloc_i.valid && alloc_1h[i]) begin
                valid_d[i] = 1'b1;
                head_d[i] = ~alloc_i.link;
                tail_d[i] = 1'b1;
                deps_d[i] = alloc_i.deps;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q <= '0;
            tail_q <= '0;
            deps_q <= '0;
        end else begin
            valid_q <= valid_d;
            head_q <= head_d;
            tail_q <= tail_d;
            deps_q <= deps_d;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_i.valid && alloc_i.link) |-> check_hit_o)
        else $error("linked allocation without a check hit");

    // Each line has at most one list in the table
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(link_tail_o))
        else $error("more than one tail matches the checked line");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_i.valid |-> !full_o)
        else $error("allocation while the table is full");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_i.valid |-> valid_q[commit_i.ptr]) and
        (rback_i.valid |-> valid_q[rback_i.ptr]))
        else $error("commit or rollback of an invalid entry");

endmodule

// ==== hw/rtab/rtab_pop_fsm.sv ====
// Pop-try controller that offers ready list heads and then walks each list to its tail
`timescale 1ns/1ps

module rtab_pop_fsm import rtab_cfg_pkg::*, rtab_types_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  rtab_bv_t  ready_i,
    input  rtab_bv_t  tail_i,
    input  rtab_ptr_t pop_next_i,
    input  logic      rback_valid_i,
    input  logic      pop_try_i,
    output logic      pop_try_valid_o,
    output rtab_ptr_t pop_ptr_o,
    output rtab_bv_t  pop_sel_o
);

    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } pop_state_e;

    pop_state_e state_q, state_d;
    rtab_ptr_t next_q, next_d;
    rtab_bv_t gnt;
    rtab_ptr_t gnt_ptr;
    logic advance;

    rtab_rr_arb rtab_rr_arb_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (ready_i),
        .advance_i (advance),
        .gnt_o     (gnt)
    );

    always_comb begin
        gnt_ptr = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (gnt[i]) begin
                gnt_ptr = rtab_ptr_t'(i);
            end
        end
    end

    always_comb begin
        state_d = state_q;
        next_d = next_q;
        advance = 1'b0;
        pop_ptr_o = gnt_ptr;
        pop_try_valid_o = |ready_i;
        case (state_q)
            POP_HEAD: begin
                if (pop_try_valid_o && pop_try_i) begin
                    advance = 1'b1;
                    if (!tail_i[gnt_ptr]) begin
                        state_d = POP_NEXT;
                        next_d = pop_next_i;
                    end
                end
            end
            POP_NEXT, POP_NEXT_WAIT: begin
                pop_ptr_o = next_q;
                pop_try_valid_o = 1'b1;
                // Rollback of the previous member puts its list back at the head
                if (state_q == POP_NEXT && rback_valid_i) begin
                    state_d = POP_HEAD;
                end else if (pop_try_i) begin
                    if (!tail_i[next_q]) begin
                        state_d = POP_NEXT;
                        next_d = pop_next_i;
                    end else begin
                        state_d = POP_HEAD;
                    end
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    always_comb begin
        pop_sel_o = '0;
        pop_sel_o[pop_ptr_o] = pop_try_valid_o;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            next_q <= '0;
        end else begin
            state_q <= state_d;
            next_q <= next_d;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rback_valid_i |-> !pop_try_i)
        else $error("pop accepted during a rollback");

endmodule

// ==== hw/rtab/rtab_rr_arb.sv ====
// Round-robin arbiter with a rotating priority mask, used to pick the next list head
`timescale 1ns/1ps

module rtab_rr_arb import rtab_types_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  rtab_bv_t req_i,
    input  logic     advance_i,
    output rtab_bv_t gnt_o
);

    // Entries allowed in the first search pass
    rtab_bv_t prio_q, prio_d;
    rtab_bv_t req_hi;

    assign req_hi = req_i & prio_q;

    // Lowest request above the priority point, otherwise wrap around
    always_comb begin
        if (|req_hi) begin
            gnt_o = req_hi & (~req_hi + 1'b1);
        end else begin
            gnt_o = req_i & (~req_i + 1'b1);
        end
    end

    always_comb begin
        prio_d = prio_q;
        if (advance_i) begin
            // Move past the entry just taken
            prio_d = ~(gnt_o | (gnt_o - 1'b1));
        end else if (|gnt_o) begin
            // Keep the offered head first in line until it is taken
            prio_d = ~(gnt_o - 1'b1);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= '1;
        end else begin
            prio_q <= prio_d;
        end
    end

endmodule

// ==== hw/rtab/rtab_store.sv ====
// Replay table request and next-pointer storage with line and set comparators
`timescale 1ns/1ps

module rtab_store import rtab_cfg_pkg::*, rtab_types_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  rtab_alloc_t alloc_i,
    input  rtab_ptr_t   alloc_ptr_i,
    input  rtab_bv_t    link_tail_i,
    input  rtab_nline_t check_nline_i,
    input  rtab_nline_t refill_nline_i,
    input  rtab_ptr_t   pop_ptr_i,
    output rtab_bv_t    check_match_o,
    output rtab_bv_t    refill_line_match_o,
    output rtab_bv_t    refill_set_match_o,
    output rtab_req_t   pop_req_o,
    output rtab_ptr_t   pop_next_o
);

    rtab_req_t [RTAB_ENTRIES-1:0] req_q;
    rtab_ptr_t [RTAB_ENTRIES-1:0] next_q;
    logic [SET_W-1:0] refill_set;

    always_ff @(posedge clk_i) begin
        if (alloc_i.valid) begin
            req_q[alloc_ptr_i] <= alloc_i.req;
        end
    end

    // The old tail points at the newly linked entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_q <= '0;
        end else if (alloc_i.valid && alloc_i.link) begin
            for (int i = 0; i < RTAB_ENTRIES; i++) begin
                if (link_tail_i[i]) begin
                    next_q[i] <= alloc_ptr_i;
                end
            end
        end
    end

    // Set index is the low part of the line number
    assign refill_set = refill_nline_i[SET_W-1:0];

    always_comb begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            check_match_o[i] = (req_q[i].addr.lo.nline == check_nline_i);
            refill_line_match_o[i] = (req_q[i].addr.lo.nline == refill_nline_i);
            refill_set_match_o[i] = (req_q[i].addr.tso.set == refill_set);
        end
    end

    assign pop_req_o = req_q[pop_ptr_i];
    assign pop_next_o = next_q[pop_ptr_i];

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_i.valid && alloc_i.link) |-> $onehot(link_tail_i))
        else $error("linked allocation needs exactly one tail");

endmodule

// ==== hw/rtab/rtab_top.sv ====
// Replay table top level, connects the flag bits, the request store and the pop controller
`timescale 1ns/1ps

module rtab_top import rtab_cfg_pkg::*, rtab_types_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  rtab_nline_t  check_nline_i,
    output logic         check_hit_o,
    input  rtab_alloc_t  alloc_i,
    input  rtab_commit_t commit_i,
    input  rtab_rback_t  rback_i,
    input  rtab_refill_t refill_i,
    input  logic         miss_ready_i,
    input  logic         pop_try_i,
    output logic         pop_try_valid_o,
    output rtab_req_t    pop_try_req_o,
    output rtab_ptr_t    pop_try_ptr_o,
    output logic         empty_o,
    output logic         full_o
);

    rtab_bv_t check_match;
    rtab_bv_t refill_line_match;
    rtab_bv_t refill_set_match;
    rtab_bv_t link_tail;
    rtab_ptr_t alloc_ptr;
    rtab_bv_t ready;
    rtab_bv_t tail;
    rtab_bv_t pop_sel;
    rtab_bv_t pop_take;
    rtab_ptr_t pop_next;

    // Entry actually taken this cycle
    assign pop_take = pop_sel & {RTAB_ENTRIES{pop_try_i}};

    rtab_flags rtab_flags_inst (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .alloc_i             (alloc_i),
        .commit_i            (commit_i),
        .rback_i             (rback_i),
        .refill_valid_i      (refill_i.valid),
        .miss_ready_i        (miss_ready_i),
        .check_match_i       (check_match),
        .refill_line_match_i (refill_line_match),
        .refill_set_match_i  (refill_set_match),
        .pop_take_i          (pop_take),
        .check_hit_o         (check_hit_o),
        .link_tail_o         (link_tail),
        .alloc_ptr_o         (alloc_ptr),
        .ready_o             (ready),
        .tail_o              (tail),
        .empty_o             (empty_o),
        .full_o              (full_o)
    );

    rtab_store rtab_store_inst (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .alloc_i             (alloc_i),
        .alloc_ptr_i         (alloc_ptr),
        .link_tail_i         (link_tail),
        .check_nline_i       (check_nline_i),
        .refill_nline_i      (refill_i.nline),
        .pop_ptr_i           (pop_try_ptr_o),
        .check_match_o       (check_match),
        .refill_line_match_o (refill_line_match),
        .refill_set_match_o  (refill_set_match),
        .pop_req_o           (pop_try_req_o),
        .pop_next_o          (pop_next)
    );

    rtab_pop_fsm rtab_pop_fsm_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ready_i         (ready),
        .tail_i          (tail),
        .pop_next_i      (pop_next),
        .rback_valid_i   (rback_i.valid),
        .pop_try_i       (pop_try_i),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_ptr_o       (pop_try_ptr_o),
        .pop_sel_o       (pop_sel)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the replay table testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f sources.f --top-module rtab_tb -o rtab_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rtab_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// ==== sources.f ====
common/rtab_cfg_pkg.sv
common/rtab_types_pkg.sv
hw/rtab/rtab_rr_arb.sv
hw/rtab/rtab_flags.sv
hw/rtab/rtab_store.sv
hw/rtab/rtab_pop_fsm.sv
hw/rtab/rtab_top.sv
dv/rtab_tb.sv
